/* all.f */
dbg_pkg.sv
dbg_req_decode.sv
dbg_access_ctrl.sv
dbg_stack_trace.sv
dbg_resp_hold.sv
dbg_port_top.sv
tb_clkgen.sv
tb_target_model.sv
tb_dbg_port.sv

/* Makefile */
# Verilator build and run of the debug port testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_dbg_port: all.f $(wildcard *.sv)
	verilator --binary --timing --top-module tb_dbg_port -f all.f -o Vtb_dbg_port

run: obj_dir/Vtb_dbg_port
	./obj_dir/Vtb_dbg_port > sim.log 2>&1; cat sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only -Wall --top-module dbg_port_top \
		dbg_pkg.sv dbg_req_decode.sv dbg_access_ctrl.sv \
		dbg_stack_trace.sv dbg_resp_hold.sv dbg_port_top.sv

clean:
	rm -rf obj_dir sim.log

/* tb_dbg_port.sv */
// Debug port testbench with stimulus, shadow reference model and response checks
`default_nettype none

module tb_dbg_port import dbg_pkg::*; ();

    logic       clk;
    logic       nrst;
    logic       req_valid;
    logic       req_ready;
    dbg_req_t   req;
    logic       resp_valid;
    logic       resp_ready;
    dbg_resp_t  resp;
    logic       csr_req_valid;
    logic       csr_req_ready;
    csr_req_t   csr_req;
    logic       csr_resp_valid;
    logic       csr_resp_ready;
    csr_resp_t  csr_resp;
    logic       mem_req_valid;
    logic       mem_req_ready;
    logic       mem_req_error;
    mem_req_t   mem_req;
    logic       mem_resp_valid;
    logic       mem_resp_ready;
    mem_resp_t  mem_resp;
    logic       ireg_ena;
    logic       ireg_write;
    ireg_idx_t  ireg_addr;
    dbg_data_t  ireg_wdata;
    dbg_data_t  ireg_rdata;
    logic       e_call;
    logic       e_ret;
    dbg_addr_t  e_pc;
    dbg_addr_t  e_npc;

    dbg_resp_t  exp_q[$];                                 // Expected responses in order
    dbg_resp_t  head;
    dbg_data_t  sh_csr [16];
    dbg_data_t  sh_reg [IREG_N];
    dbg_data_t  sh_mem [256];
    dbg_addr_t  sh_call [STK_SIZE];
    dbg_addr_t  sh_ret [STK_SIZE];
    int         sh_depth;
    int         accepted;
    int         taken;
    logic       stall_mode;                               // Random host back-pressure

    tb_clkgen u_clkgen (.o_clk(clk), .o_nrst(nrst));

    dbg_port_top uut (
        .i_clk(clk), .i_nrst(nrst),
        .i_dport_req_valid(req_valid), .i_dport_req(req), .o_dport_req_ready(req_ready),
        .o_dport_resp_valid(resp_valid), .o_dport_resp(resp), .i_dport_resp_ready(resp_ready),
        .o_csr_req_valid(csr_req_valid), .o_csr_req(csr_req), .i_csr_req_ready(csr_req_ready),
        .i_csr_resp_valid(csr_resp_valid), .i_csr_resp(csr_resp),
        .o_csr_resp_ready(csr_resp_ready),
        .o_mem_req_valid(mem_req_valid), .o_mem_req(mem_req), .i_mem_req_ready(mem_req_ready),
        .i_mem_req_error(mem_req_error), .i_mem_resp_valid(mem_resp_valid),
        .i_mem_resp(mem_resp), .o_mem_resp_ready(mem_resp_ready),
        .o_ireg_ena(ireg_ena), .o_ireg_write(ireg_write), .o_ireg_addr(ireg_addr),
        .o_ireg_wdata(ireg_wdata), .i_ireg_rdata(ireg_rdata),
        .i_e_call(e_call), .i_e_ret(e_ret), .i_e_pc(e_pc), .i_e_npc(e_npc)
    );

    tb_target_model u_model (
        .i_clk(clk), .i_nrst(nrst),
        .i_csr_req_valid(csr_req_valid), .i_csr_req(csr_req), .o_csr_req_ready(csr_req_ready),
        .o_csr_resp_valid(csr_resp_valid), .o_csr_resp(csr_resp),
        .i_mem_req_valid(mem_req_valid), .i_mem_req(mem_req), .o_mem_req_ready(mem_req_ready),
        .o_mem_req_error(mem_req_error), .o_mem_resp_valid(mem_resp_valid),
        .o_mem_resp(mem_resp),
        .i_ireg_ena(ireg_ena), .i_ireg_write(ireg_write), .i_ireg_addr(ireg_addr),
        .i_ireg_wdata(ireg_wdata), .o_ireg_rdata(ireg_rdata)
    );

    task automatic abort(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic dbg_req_t reg_req(input logic wr, input dbg_addr_t a, input dbg_data_t d);
        return '{reg_access: 1'b1, mem_access: 1'b0, write: wr, addr: a, wdata: d, size: 2'd2};
    endfunction

    function automatic dbg_req_t mem_rq(input logic wr, input dbg_addr_t a, input dbg_data_t d);
        return '{reg_access: 1'b0, mem_access: 1'b1, write: wr, addr: a, wdata: d, size: 2'd2};
    endfunction

    function automatic dbg_resp_t ok(input dbg_data_t d);
        return '{error: 1'b0, rdata: d};
    endfunction

    // Holds the request until the port takes it
    task automatic send(input dbg_req_t r, input dbg_resp_t e);
        int n;
        n = 0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
            n++;
            if (n > 200) abort("Timeout: request was never accepted by the debug port");
        end
        assert (accepted - taken < 3) else abort("More than three requests were in flight");
        exp_q.push_back(e);
        accepted++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 200) abort("Timeout: expected responses never came back");
        end
    endtask

    task automatic core_event(input logic call, input dbg_addr_t pc);
        e_call = call;
        e_ret  = ~call;
        e_pc   = pc;
        e_npc  = pc + 32'd4;
        if (call && sh_depth != STK_SIZE - 1) begin
            sh_call[sh_depth] = pc;
            sh_ret[sh_depth]  = pc + 32'd4;
            sh_depth++;
        end else if (!call && sh_depth != 0) begin
            sh_depth--;
        end
        @(negedge clk);
        e_call = 1'b0;
        e_ret  = 1'b0;
    endtask

    // Host side of the response channel
    always @(negedge clk) begin
        if (!nrst) begin
            resp_ready = 1'b0;
        end else begin
            resp_ready = stall_mode ? ($urandom % 4 == 0) : 1'b1;
            if (resp_valid && resp_ready) begin
                assert (exp_q.size() > 0) else abort("A response arrived with none expected");
                head = exp_q.pop_front();
                assert (resp.error == head.error) else abort($sformatf(
                    "Fail o_dport_resp.error got %h expected %h", resp.error, head.error));
                assert (resp.rdata == head.rdata) else abort($sformatf(
                    "Fail o_dport_resp.rdata got %h expected %h", resp.rdata, head.rdata));
                taken++;
            end
        end
    end

    // Target responses are offered for one cycle and must be taken on that edge
    always @(posedge clk) begin
        if (nrst && csr_resp_valid) begin
            assert (csr_resp_ready) else abort($sformatf(
                "Fail o_csr_resp_ready got %h expected %h", csr_resp_ready, 1'b1));
        end
        if (nrst && mem_resp_valid) begin
            assert (mem_resp_ready) else abort($sformatf(
                "Fail o_mem_resp_ready got %h expected %h", mem_resp_ready, 1'b1));
        end
    end

    initial begin
        int a;
        int n;
        dbg_data_t d;
        void'($urandom(32'hde99cf5e));
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        e_call     = 1'b0;
        e_ret      = 1'b0;
        e_pc       = '0;
        e_npc      = '0;
        stall_mode = 1'b0;
        accepted   = 0;
        taken      = 0;
        sh_depth   = 0;
        foreach (sh_csr[i]) sh_csr[i] = 32'hc000_0000 + i;  // Model contents after reset
        foreach (sh_reg[i]) sh_reg[i] = 32'h1000_0000 + i;
        foreach (sh_mem[i]) sh_mem[i] = 32'h4000_0000 + i;
        n = 0;
        while (!nrst) begin
            @(negedge clk);
            n++;
            if (n > 200) abort("Timeout: reset was never released");
        end
        @(negedge clk);
        for (int i = 0; i < 8; i++) begin                 // CSR round trips
            a = $urandom % 16;
            d = $urandom;
            sh_csr[a] = d;
            send(reg_req(1'b1, a, d), ok(d));
            send(reg_req(1'b0, a, '0), ok(sh_csr[a]));
        end
        send(reg_req(1'b0, 32'h0000_0123, '0), '{error: 1'b1, rdata: '0});
        for (int i = 0; i < 8; i++) begin                 // Register file round trips
            a = $urandom % IREG_N;
            d = $urandom;
            send(reg_req(1'b1, 32'h1000 | a, d), ok(sh_reg[a]));
            sh_reg[a] = d;
            send(reg_req(1'b0, 32'h1000 | a, '0), ok(d));
        end
        for (int i = 0; i < 8; i++) begin                 // Memory round trips
            a = $urandom % 256;
            d = $urandom;
            sh_mem[a] = d;
            send(mem_rq(1'b1, a * 4, d), ok(d));
            send(mem_rq(1'b0, a * 4, '0), ok(sh_mem[a]));
        end
        send(mem_rq(1'b1, 32'h0000_0800, 32'h1234_5678), '{error: 1'b1, rdata: '1});
        send(mem_rq(1'b0, 32'h0001_0000, '0), '{error: 1'b1, rdata: '1});
        drain();
        for (int i = 0; i < 10; i++) core_event(1'b1, $urandom & 32'hffff_fffc);
        for (int i = 0; i < 3; i++) core_event(1'b0, '0);
        core_event(1'b1, 32'h0000_4000);
        send(reg_req(1'b0, 32'hc040, '0), ok(sh_depth));
        for (int k = 0; k < sh_depth; k++) begin
            send(reg_req(1'b0, 32'hc080 + 2 * k, '0), ok(sh_call[k]));
            send(reg_req(1'b0, 32'hc081 + 2 * k, '0), ok(sh_ret[k]));
        end
        send(reg_req(1'b1, 32'hc040, 32'd2), ok(sh_depth));
        sh_depth = 2;
        send(reg_req(1'b0, 32'hc040, '0), ok(32'd2));
        drain();
        send('{reg_access: 1'b0, mem_access: 1'b0, write: 1'b0, addr: '0, wdata: '0,
               size: 2'd2}, '{error: 1'b1, rdata: '0});
        send(reg_req(1'b0, 32'h5000, '0), '{error: 1'b1, rdata: '0});
        send(reg_req(1'b0, 32'hc044, '0), '{error: 1'b1, rdata: '0});
        drain();
        stall_mode = 1'b1;                                // Back-to-back under back-pressure
        for (int i = 0; i < 30; i++) begin
            a = $urandom % 16;
            d = $urandom;
            case ($urandom % 3)
                0: begin
                    sh_csr[a] = d;
                    send(reg_req(1'b1, a, d), ok(d));
                end
                1: send(reg_req(1'b0, 32'h1000 | a, '0), ok(sh_reg[a]));
                default: send(mem_rq(1'b0, a * 4, '0), ok(sh_mem[a]));
            endcase
        end
        drain();
        stall_mode = 1'b0;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_target_model.sv */
// Behavioral CSR bank, register file and data memory with random handshake stalls
`default_nettype none

module tb_target_model import dbg_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    input  wire logic      i_csr_req_valid,
    input  wire csr_req_t  i_csr_req,
    output logic           o_csr_req_ready,
    output logic           o_csr_resp_valid,
    output csr_resp_t      o_csr_resp,
    input  wire logic      i_mem_req_valid,
    input  wire mem_req_t  i_mem_req,
    output logic           o_mem_req_ready,
    output logic           o_mem_req_error,
    output logic           o_mem_resp_valid,
    output mem_resp_t      o_mem_resp,
    input  wire logic      i_ireg_ena,
    input  wire logic      i_ireg_write,
    input  wire ireg_idx_t i_ireg_addr,
    input  wire dbg_data_t i_ireg_wdata,
    output dbg_data_t      o_ireg_rdata
);

    dbg_data_t csr [16];
    dbg_data_t regs [IREG_N];
    dbg_data_t mem [256];
    int        csr_wait;
    int        csr_rwait;
    int        mem_wait;
    int        mem_rwait;
    logic      csr_busy;                                  // Response owed to the executor
    logic      mem_busy;

    initial begin
        foreach (csr[i]) csr[i] = 32'hc000_0000 + i;      // Contents tagged by index
        foreach (mem[i]) mem[i] = 32'h4000_0000 + i;
    end

    assign o_ireg_rdata = regs[i_ireg_addr];              // Read before the write lands

    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            foreach (regs[i]) regs[i] <= 32'h1000_0000 + i;
        end else if (i_ireg_ena && i_ireg_write) begin
            regs[i_ireg_addr] <= i_ireg_wdata;
        end
    end

    // Ready is raised only while valid is up, so each high cycle is a handshake
    always @(negedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_csr_req_ready  = 1'b0;
            o_csr_resp_valid = 1'b0;
            o_csr_resp       = '0;
            csr_busy         = 1'b0;
            csr_wait         = 0;
            csr_rwait        = 0;
        end else if (o_csr_req_ready) begin
            o_csr_req_ready = 1'b0;
            csr_busy        = 1'b1;
            csr_rwait       = $urandom % 4;
            if (i_csr_req.addr < 12'd16) begin
                if (i_csr_req.write) begin
                    csr[i_csr_req.addr[3:0]] = i_csr_req.data;
                end
                o_csr_resp = '{exception: 1'b0, data: csr[i_csr_req.addr[3:0]]};
            end else begin
                o_csr_resp = '{exception: 1'b1, data: '0};  // Unimplemented CSR
            end
        end else if (o_csr_resp_valid) begin
            o_csr_resp_valid = 1'b0;
            csr_busy         = 1'b0;
            csr_wait         = $urandom % 4;
        end else if (csr_busy) begin
            if (csr_rwait == 0) o_csr_resp_valid = 1'b1;
            else csr_rwait--;
        end else if (i_csr_req_valid) begin
            if (csr_wait == 0) o_csr_req_ready = 1'b1;
            else csr_wait--;
        end
    end

    always @(negedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_mem_req_ready  = 1'b0;
            o_mem_req_error  = 1'b0;
            o_mem_resp_valid = 1'b0;
            o_mem_resp       = '0;
            mem_busy         = 1'b0;
            mem_wait         = 0;
            mem_rwait        = 0;
        end else if (o_mem_req_ready) begin
            o_mem_req_ready = 1'b0;
            mem_rwait       = $urandom % 4;
            mem_wait        = $urandom % 4;
            if (!o_mem_req_error) begin
                if (i_mem_req.write) begin
                    mem[i_mem_req.addr[9:2]] = i_mem_req.wdata;
                end
                o_mem_resp = '{error: 1'b0, rdata: mem[i_mem_req.addr[9:2]]};
                mem_busy   = 1'b1;
            end
            o_mem_req_error = 1'b0;
        end else if (o_mem_resp_valid) begin
            o_mem_resp_valid = 1'b0;
            mem_busy         = 1'b0;
        end else if (mem_busy) begin
            if (mem_rwait == 0) o_mem_resp_valid = 1'b1;
            else mem_rwait--;
        end else if (i_mem_req_valid) begin
            if (mem_wait == 0) begin
                o_mem_req_ready = 1'b1;
                o_mem_req_error = (i_mem_req.addr >= 32'd1024);  // Outside the memory
            end else begin
                mem_wait--;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock generator and reset sequencer
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #5 o_clk = ~o_clk;                            // Period of 10
        end
    end

    initial begin
        o_nrst = 1'b0;
        repeat (16) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;                                    // Release away from the active edge
    end

endmodule

`default_nettype wire

/* dbg_port_top.sv */
// Debug port top level with decode, executor, response register and trace buffer
`default_nettype none

module dbg_port_top import dbg_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    // Host channel
    input  wire logic      i_dport_req_valid,
    input  wire dbg_req_t  i_dport_req,
    output logic           o_dport_req_ready,
    output logic           o_dport_resp_valid,
    output dbg_resp_t      o_dport_resp,
    input  wire logic      i_dport_resp_ready,
    // CSR bank
    output logic           o_csr_req_valid,
    output csr_req_t       o_csr_req,
    input  wire logic      i_csr_req_ready,
    input  wire logic      i_csr_resp_valid,
    input  wire csr_resp_t i_csr_resp,
    output logic           o_csr_resp_ready,
    // Data memory
    output logic           o_mem_req_valid,
    output mem_req_t       o_mem_req,
    input  wire logic      i_mem_req_ready,
    input  wire logic      i_mem_req_error,
    input  wire logic      i_mem_resp_valid,
    input  wire mem_resp_t i_mem_resp,
    output logic           o_mem_resp_ready,
    // Integer register file
    output logic           o_ireg_ena,
    output logic           o_ireg_write,
    output ireg_idx_t      o_ireg_addr,
    output dbg_data_t      o_ireg_wdata,
    input  wire dbg_data_t i_ireg_rdata,
    // Core call/return reports
    input  wire logic      i_e_call,
    input  wire logic      i_e_ret,
    input  wire dbg_addr_t i_e_pc,
    input  wire dbg_addr_t i_e_npc
);

    logic       cmd_valid;
    logic       cmd_ready;
    dbg_cmd_t   cmd;
    logic       res_valid;
    logic       res_ready;
    dbg_resp_t  res;
    logic       stk_cnt_we;
    stk_cnt_t   stk_cnt_wdata;
    stk_cnt_t   stk_cnt;
    stk_cnt_t   stk_raddr;
    stk_entry_t stk_rdata;

    dbg_req_decode u_decode (
        .i_clk, .i_nrst, .i_dport_req_valid, .i_dport_req, .o_dport_req_ready,
        .o_cmd_valid(cmd_valid), .o_cmd(cmd), .i_cmd_ready(cmd_ready)
    );

    dbg_access_ctrl u_exec (
        .i_clk, .i_nrst,
        .i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_ready(cmd_ready),
        .o_res_valid(res_valid), .o_res(res), .i_res_ready(res_ready),
        .o_csr_req_valid, .o_csr_req, .i_csr_req_ready,
        .i_csr_resp_valid, .i_csr_resp, .o_csr_resp_ready,
        .o_ireg_ena, .o_ireg_write, .o_ireg_addr, .o_ireg_wdata, .i_ireg_rdata,
        .o_mem_req_valid, .o_mem_req, .i_mem_req_ready, .i_mem_req_error,
        .i_mem_resp_valid, .i_mem_resp, .o_mem_resp_ready,
        .o_stk_cnt_we(stk_cnt_we), .o_stk_cnt_wdata(stk_cnt_wdata), .i_stk_cnt(stk_cnt),
        .o_stk_raddr(stk_raddr), .i_stk_rdata(stk_rdata)
    );

    dbg_stack_trace u_trace (
        .i_clk, .i_nrst, .i_e_call, .i_e_ret, .i_e_pc, .i_e_npc,
        .i_cnt_we(stk_cnt_we), .i_cnt_wdata(stk_cnt_wdata), .o_cnt(stk_cnt),
        .i_raddr(stk_raddr), .o_rdata(stk_rdata)
    );

    dbg_resp_hold u_result (
        .i_clk, .i_nrst,
        .i_res_valid(res_valid), .i_res(res), .o_res_ready(res_ready),
        .o_dport_resp_valid, .o_dport_resp, .i_dport_resp_ready
    );

endmodule

`default_nettype wire

/* dbg_resp_hold.sv */
// One-entry response register between the executor and the host
`default_nettype none

module dbg_resp_hold import dbg_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    input  wire logic      i_res_valid,
    input  wire dbg_resp_t i_res,
    output logic           o_res_ready,
    output logic           o_dport_resp_valid,
    output dbg_resp_t      o_dport_resp,
    input  wire logic      i_dport_resp_ready
);

    logic      full;
    dbg_resp_t resp_q;

    assign o_res_ready = ~full;                           // Accept only into an empty slot

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            full <= 1'b0;
        end else if (i_res_valid && o_res_ready) begin
            full <= 1'b1;
        end else if (i_dport_resp_ready) begin
            full <= 1'b0;                                 // Host took the response
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_res_valid && o_res_ready) begin
            resp_q <= i_res;
        end
    end

    assign o_dport_resp_valid = full;
    assign o_dport_resp       = resp_q;

endmodule

`default_nettype wire

/* dbg_stack_trace.sv */
// Call-depth counter and call-stack trace memory with registered read port
`default_nettype none

module dbg_stack_trace import dbg_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    // Core call/return reports
    input  wire logic      i_e_call,
    input  wire logic      i_e_ret,
    input  wire dbg_addr_t i_e_pc,
    input  wire dbg_addr_t i_e_npc,
    // Debugger access
    input  wire logic      i_cnt_we,
    input  wire stk_cnt_t  i_cnt_wdata,
    output stk_cnt_t       o_cnt,
    input  wire stk_cnt_t  i_raddr,
    output stk_entry_t     o_rdata
);

    stk_entry_t mem [STK_SIZE];
    stk_cnt_t   cnt;
    logic       push;
    logic       pop;

    // Last slot is never filled, so a full buffer drops further calls
    assign push = i_e_call && (cnt != stk_cnt_t'(STK_SIZE - 1)) && !i_cnt_we;
    assign pop  = i_e_ret && (cnt != '0) && !i_e_call && !i_cnt_we;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt <= '0;
        end else if (i_cnt_we) begin
            cnt <= i_cnt_wdata;                           // Debugger write wins
        end else if (push) begin
            cnt <= cnt + 1'b1;
        end else if (pop) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[cnt] <= '{ret_addr: i_e_npc, call_addr: i_e_pc};
        end
        o_rdata <= mem[i_raddr];
    end

    assign o_cnt = cnt;

endmodule

`default_nettype wire

/* dbg_access_ctrl.sv */
// Command executor FSM for CSR, register file, trace buffer and memory targets
`default_nettype none

module dbg_access_ctrl import dbg_pkg::*; (
    input  wire logic       i_clk,
    input  wire logic       i_nrst,
    // Command from decode
    input  wire logic       i_cmd_valid,
    input  wire dbg_cmd_t   i_cmd,
    output logic            o_cmd_ready,
    // Result to the response register
    output logic            o_res_valid,
    output dbg_resp_t       o_res,
    input  wire logic       i_res_ready,
    // CSR bank
    output logic            o_csr_req_valid,
    output csr_req_t        o_csr_req,
    input  wire logic       i_csr_req_ready,
    input  wire logic       i_csr_resp_valid,
    input  wire csr_resp_t  i_csr_resp,
    output logic            o_csr_resp_ready,
    // Integer register file
    output logic            o_ireg_ena,
    output logic            o_ireg_write,
    output ireg_idx_t       o_ireg_addr,
    output dbg_data_t       o_ireg_wdata,
    input  wire dbg_data_t  i_ireg_rdata,
    // Data memory
    output logic            o_mem_req_valid,
    output mem_req_t        o_mem_req,
    input  wire logic       i_mem_req_ready,
    input  wire logic       i_mem_req_error,
    input  wire logic       i_mem_resp_valid,
    input  wire mem_resp_t  i_mem_resp,
    output logic            o_mem_resp_ready,
    // Trace buffer
    output logic            o_stk_cnt_we,
    output stk_cnt_t        o_stk_cnt_wdata,
    input  wire stk_cnt_t   i_stk_cnt,
    output stk_cnt_t        o_stk_raddr,
    input  wire stk_entry_t i_stk_rdata
);

    dbg_exec_state_e state;
    dbg_exec_state_e state_nxt;
    dbg_cmd_t        cmd_r;                               // Command under execution
    dbg_resp_t       res_r;
    dbg_resp_t       res_nxt;

    assign o_cmd_ready = (state == idle);
    assign o_res_valid = (state == done);
    assign o_res       = res_r;

    // Target payloads come straight from the held command
    assign o_csr_req.write   = cmd_r.write;
    assign o_csr_req.addr    = cmd_r.addr[11:0];
    assign o_csr_req.data    = cmd_r.wdata;
    assign o_ireg_addr       = cmd_r.addr[IREG_W-1:0];
    assign o_ireg_wdata      = cmd_r.wdata;
    assign o_mem_req.write   = cmd_r.write;
    assign o_mem_req.addr    = cmd_r.addr;
    assign o_mem_req.size    = cmd_r.size;
    assign o_mem_req.wdata   = cmd_r.wdata;
    assign o_stk_cnt_wdata   = cmd_r.wdata[STK_LOG2-1:0];
    assign o_stk_raddr       = cmd_r.addr[STK_LOG2:1];    // Entry index, bit 0 picks the half

    always_comb begin
        state_nxt        = state;
        res_nxt          = res_r;
        o_csr_req_valid  = 1'b0;
        o_csr_resp_ready = 1'b0;
        o_ireg_ena       = 1'b0;
        o_ireg_write     = 1'b0;
        o_mem_req_valid  = 1'b0;
        o_mem_resp_ready = 1'b0;
        o_stk_cnt_we     = 1'b0;
        case (state)
            idle: begin
                if (i_cmd_valid) begin
                    case (i_cmd.kind)
                        cmd_csr:     state_nxt = csr_req;
                        cmd_ireg:    state_nxt = ireg;
                        cmd_stk_cnt: state_nxt = stk_cnt;
                        cmd_stk_buf: state_nxt = stk_rd;
                        cmd_mem:     state_nxt = mem_req;
                        default: begin
                            res_nxt.error = 1'b1;         // Unsupported request
                            res_nxt.rdata = '0;
                            state_nxt     = done;
                        end
                    endcase
                end
            end
            csr_req: begin
                o_csr_req_valid = 1'b1;
                if (i_csr_req_ready) begin
                    state_nxt = csr_resp;
                end
            end
            csr_resp: begin
                o_csr_resp_ready = 1'b1;
                if (i_csr_resp_valid) begin
                    res_nxt.error = i_csr_resp.exception;
                    res_nxt.rdata = i_csr_resp.data;
                    state_nxt     = done;
                end
            end
            ireg: begin
                o_ireg_ena    = 1'b1;
                o_ireg_write  = cmd_r.write;
                res_nxt.error = 1'b0;
                res_nxt.rdata = i_ireg_rdata;             // Same-cycle read
                state_nxt     = done;
            end
            stk_cnt: begin
                o_stk_cnt_we  = cmd_r.write;
                res_nxt.error = 1'b0;
                res_nxt.rdata = dbg_data_t'(i_stk_cnt);   // Depth before any write
                state_nxt     = done;
            end
            stk_rd: begin
                state_nxt = stk_dat;                      // Wait for registered read
            end
            stk_dat: begin
                res_nxt.error = 1'b0;
                res_nxt.rdata = cmd_r.addr[0] ? i_stk_rdata.ret_addr : i_stk_rdata.call_addr;
                state_nxt     = done;
            end
            mem_req: begin
                o_mem_req_valid = 1'b1;
                if (i_mem_req_ready) begin
                    if (i_mem_req_error) begin
                        res_nxt.error = 1'b1;             // Access refused
                        res_nxt.rdata = '1;
                        state_nxt     = done;
                    end else begin
                        state_nxt = mem_resp;
                    end
                end
            end
            mem_resp: begin
                o_mem_resp_ready = 1'b1;
                if (i_mem_resp_valid) begin
                    res_nxt.error = i_mem_resp.error;
                    res_nxt.rdata = i_mem_resp.rdata;
                    state_nxt     = done;
                end
            end
            done: begin
                if (i_res_ready) begin
                    state_nxt = idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd_valid && o_cmd_ready) begin
            cmd_r <= i_cmd;
        end
        res_r <= res_nxt;
    end

endmodule

`default_nettype wire

/* dbg_req_decode.sv */
// Host request acceptance, command classification and one-entry command slot
`default_nettype none

module dbg_req_decode import dbg_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_nrst,
    input  wire logic     i_dport_req_valid,
    input  wire dbg_req_t i_dport_req,
    output logic          o_dport_req_ready,
    output logic          o_cmd_valid,
    output dbg_cmd_t      o_cmd,
    input  wire logic     i_cmd_ready
);

    logic     full;                                       // Command slot occupied
    dbg_cmd_t cmd_q;
    dbg_cmd_t cmd_d;

    function automatic dbg_cmd_kind_e classify(input dbg_req_t req);
        logic [3:0]  region;
        logic [11:0] idx;
        region = req.addr[15:12];
        idx    = req.addr[11:0];
        if (req.mem_access) begin
            return cmd_mem;
        end
        if (!req.reg_access) begin
            return cmd_bad;                               // Neither access flag set
        end
        case (region)
            REGION_CSR:  return cmd_csr;
            REGION_IREG: return cmd_ireg;
            REGION_EXT: begin
                if (idx == EXT_STK_CNT) begin
                    return cmd_stk_cnt;
                end
                if (idx >= EXT_STK_BUF && idx < EXT_STK_BUF + 12'(2 * STK_SIZE)) begin
                    return cmd_stk_buf;                   // Two words per entry
                end
                return cmd_bad;
            end
            default:     return cmd_bad;
        endcase
    endfunction

    always_comb begin
        cmd_d.kind  = classify(i_dport_req);
        cmd_d.write = i_dport_req.write;
        cmd_d.addr  = i_dport_req.addr;
        cmd_d.wdata = i_dport_req.wdata;
        cmd_d.size  = i_dport_req.size;
    end

    // Slot refills on the same edge the executor drains it
    assign o_dport_req_ready = ~full | i_cmd_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            full <= 1'b0;
        end else if (i_dport_req_valid && o_dport_req_ready) begin
            full <= 1'b1;
        end else if (i_cmd_ready) begin
            full <= 1'b0;                                 // Drained without refill
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dport_req_valid && o_dport_req_ready) begin
            cmd_q <= cmd_d;
        end
    end

    assign o_cmd_valid = full;
    assign o_cmd       = cmd_q;

endmodule

`default_nettype wire

/* dbg_pkg.sv */
// Debug port widths, address map constants, channel structs and FSM state type
`default_nettype none

package dbg_pkg;

    localparam int XLEN     = 32;
    localparam int ADDR_W   = 32;
    localparam int IREG_N   = 32;
    localparam int IREG_W   = $clog2(IREG_N);             // Register index width
    localparam int STK_LOG2 = 3;
    localparam int STK_SIZE = 8;                          // Trace buffer depth

    // Register access regions, taken from address bits 15:12
    localparam logic [3:0]  REGION_CSR  = 4'h0;
    localparam logic [3:0]  REGION_IREG = 4'h1;
    localparam logic [3:0]  REGION_EXT  = 4'hc;
    localparam logic [11:0] EXT_STK_CNT = 12'h040;        // Trace depth register
    localparam logic [11:0] EXT_STK_BUF = 12'h080;        // First trace buffer word

    typedef logic [XLEN-1:0]     dbg_data_t;
    typedef logic [ADDR_W-1:0]   dbg_addr_t;
    typedef logic [IREG_W-1:0]   ireg_idx_t;
    typedef logic [STK_LOG2-1:0] stk_cnt_t;

    typedef struct packed {
        dbg_addr_t ret_addr;                              // Odd buffer word
        dbg_addr_t call_addr;                             // Even buffer word
    } stk_entry_t;

    typedef struct packed {
        logic       reg_access;
        logic       mem_access;
        logic       write;
        dbg_addr_t  addr;
        dbg_data_t  wdata;
        logic [1:0] size;
    } dbg_req_t;

    typedef enum logic [2:0] {
        cmd_csr, cmd_ireg, cmd_stk_cnt, cmd_stk_buf, cmd_mem, cmd_bad
    } dbg_cmd_kind_e;

    typedef struct packed {
        dbg_cmd_kind_e kind;
        logic          write;
        dbg_addr_t     addr;
        dbg_data_t     wdata;
        logic [1:0]    size;
    } dbg_cmd_t;

    typedef struct packed {
        logic      error;
        dbg_data_t rdata;
    } dbg_resp_t;

    typedef struct packed {
        logic        write;
        logic [11:0] addr;
        dbg_data_t   data;
    } csr_req_t;

    typedef struct packed {
        logic      exception;
        dbg_data_t data;
    } csr_resp_t;

    typedef struct packed {
        logic       write;
        dbg_addr_t  addr;
        logic [1:0] size;
        dbg_data_t  wdata;
    } mem_req_t;

    typedef struct packed {
        logic      error;
        dbg_data_t rdata;
    } mem_resp_t;

    typedef enum logic [3:0] {
        idle, csr_req, csr_resp, ireg, stk_cnt, stk_rd, stk_dat, mem_req, mem_resp, done
    } dbg_exec_state_e;

endpackage

`default_nettype wire
